// File: source/vdec_config.svh
// sizing macros for the vector decode sequencer, included by the package and by RTL that needs them
`ifndef VDEC_CONFIG_SVH
`define VDEC_CONFIG_SVH

// elements per vector register at SEW32
// kept small so simulation runs stay short
`define VLEN 16

// width of an element index or a register offset
`define IDX_W 8

// lanes issued per cycle
// the sequencer datapath is built for exactly two
`define NUM_LANES 2

`endif

// File: source/vdec_pkg.sv
// types shared by the decode sequencer RTL and its testbench, compiled ahead of every user
`include "vdec_config.svh"

package vdec_pkg;

  // element index or register offset
  typedef logic [`IDX_W-1:0] idx_t;

  // kind of decoded micro-op
  typedef enum logic [1:0] {
    OP_ALU    = 2'd0,
    OP_LOAD   = 2'd1,
    OP_STORE  = 2'd2,
    OP_MV_S_X = 2'd3
  } vop_e;

  // selected element width from vtype
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  // element width encoded in a unit-stride load or store
  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  // where the vs2 read offsets come from
  typedef enum logic [2:0] {
    VS2_NORMAL        = 3'd0,
    VS2_ZERO          = 3'd1,
    VS2_IDX_PLUS_RS1  = 3'd2,
    VS2_IDX_PLUS_UIMM = 3'd3,
    VS2_IDX_PLUS_1    = 3'd4,
    VS2_IDX_MINUS_1   = 3'd5,
    VS2_RS1           = 3'd6,
    VS2_UIMM          = 3'd7
  } vs2_src_e;

  // where the vd write offsets come from
  typedef enum logic [2:0] {
    VD_NORMAL        = 3'd0,
    VD_ZERO          = 3'd1,
    VD_IDX_PLUS_RS1  = 3'd2,
    VD_IDX_PLUS_UIMM = 3'd3,
    VD_IDX_PLUS_1    = 3'd4
  } vd_src_e;

  // sequencer states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } fsm_state_e;

endpackage

// File: source/elem_count_if.sv
// element counter handshake between the sequencer FSM, the counter and the offset logic
`include "vdec_config.svh"

interface elem_count_if;
  // one-cycle pulse on an accepted start
  logic              load;
  // move on to the next element pair
  logic              step;
  // element index of lane 0 in the current pair
  logic [`IDX_W-1:0] offset;
  // element count after load/store scaling
  logic [`IDX_W-1:0] vl_eff;
  // current pair is the final one of the run
  logic              last;

  modport fsm (output load, output step, input last);

  modport counter (input load, input step, output offset, output vl_eff, output last);

  // offset consumers only look at the count
  modport user (input offset, input vl_eff);

endinterface

// File: source/vdec_fsm.sv
// busy/run sequencer FSM that accepts one micro-op and steers the element counter through it
module vdec_fsm (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       start,
  input  logic       stall,
  input  logic       flush,
  output logic       busy,
  output logic       issue,
  elem_count_if.fsm  ctr
);
  import vdec_pkg::*;

  fsm_state_e state;
  fsm_state_e state_next;
  logic       accept;

  // new work only from idle, and a flush wins over it
  assign accept = (state == IDLE) && start && !flush;

  // busy covers the start cycle itself
  assign busy = (state != IDLE) || accept;

  // one pair per unstalled cycle in RUN
  assign issue = (state == RUN) && !stall && !flush;

  assign ctr.load = accept;
  assign ctr.step = issue;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = RUN;
        end
      end
      RUN: begin
        // the final pair is registered on this edge
        if (issue && ctr.last) begin
          state_next = DRAIN;
        end
      end
      DRAIN: begin
        if (!stall) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
    if (flush) begin
      state_next = IDLE;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // upstream waits for busy to drop before it sends the next micro-op
  a_no_start_while_busy: assert property (
    @(posedge CLK) disable iff (!nRST) (state != IDLE) |-> !start
  );

endmodule

// File: source/element_counter.sv
// element index counter that scales vl into the effective length and walks it two at a time
module element_counter (
  input  logic               CLK,
  input  logic               nRST,
  input  vdec_pkg::vop_e     op,
  input  vdec_pkg::sew_e     sew,
  input  vdec_pkg::eew_e     eew,
  input  vdec_pkg::idx_t     vl,
  input  vdec_pkg::idx_t     vstart,
  elem_count_if.counter      ctr
);
  import vdec_pkg::*;

  idx_t                  offset_q;
  idx_t                  vl_eff_q;
  idx_t                  vl_calc;
  logic [$bits(idx_t):0] pair_end;

  // effective length for the op being loaded
  always_comb begin
    vl_calc = vl;
    if (op == OP_LOAD || op == OP_STORE) begin
      // narrower memory elements pack more of them per access
      if (sew == SEW32 && eew == EEW8) begin
        vl_calc = vl >> 2;
      end else if ((sew == SEW32 && eew == EEW16) || (sew == SEW16 && eew == EEW8)) begin
        vl_calc = vl >> 1;
      end
    end else if (op == OP_MV_S_X) begin
      // single element move
      vl_calc = idx_t'(1);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      offset_q <= '0;
      vl_eff_q <= '0;
    end else if (ctr.load) begin
      offset_q <= vstart;
      vl_eff_q <= vl_calc;
    end else if (ctr.step) begin
      offset_q <= offset_q + idx_t'(2);
    end
  end

  // one bit wider so a vstart near the top cannot wrap
  assign pair_end = {1'b0, offset_q} + {1'b0, idx_t'(2)};

  // also true right away when vstart is already past the end
  assign ctr.last   = pair_end >= {1'b0, vl_eff_q};
  assign ctr.offset = offset_q;
  assign ctr.vl_eff = vl_eff_q;

  // the FSM never steps past the final pair
  a_no_step_after_last: assert property (
    @(posedge CLK) disable iff (!nRST)
    ctr.step && ctr.last |=> !ctr.step
  );

endmodule

// File: source/offset_gen.sv
// register file offset selection for vs2 reads and vd writes on both lanes of a pair
module offset_gen (
  elem_count_if.user          ctr,
  input  vdec_pkg::vs2_src_e  vs2_src,
  input  vdec_pkg::vd_src_e   vd_src,
  input  vdec_pkg::idx_t      xs1,
  input  logic [4:0]          imm5,
  output vdec_pkg::idx_t      vd_off0,
  output vdec_pkg::idx_t      vd_off1,
  output vdec_pkg::idx_t      vs2_off0,
  output vdec_pkg::idx_t      vs2_off1
);
  import vdec_pkg::*;

  idx_t base;
  idx_t uimm;
  idx_t idx_rs1;
  idx_t idx_uimm;

  assign base = ctr.offset;

  // immediate is unsigned here
  assign uimm = idx_t'(imm5);

  // sums shared by the vs2 and vd selects
  assign idx_rs1  = base + xs1;
  assign idx_uimm = base + uimm;

  always_comb begin
    case (vs2_src)
      VS2_ZERO: begin
        vs2_off0 = '0;
        vs2_off1 = '0;
      end
      VS2_IDX_PLUS_RS1: begin
        vs2_off0 = idx_rs1;
        vs2_off1 = idx_rs1 + idx_t'(1);
      end
      VS2_IDX_PLUS_UIMM: begin
        vs2_off0 = idx_uimm;
        vs2_off1 = idx_uimm + idx_t'(1);
      end
      // slide by one element
      VS2_IDX_PLUS_1: begin
        vs2_off0 = base + idx_t'(1);
        vs2_off1 = base + idx_t'(2);
      end
      VS2_IDX_MINUS_1: begin
        vs2_off0 = base - idx_t'(1);
        vs2_off1 = base;
      end
      // gather style, same element on both lanes
      VS2_RS1: begin
        vs2_off0 = xs1;
        vs2_off1 = xs1;
      end
      VS2_UIMM: begin
        vs2_off0 = uimm;
        vs2_off1 = uimm;
      end
      default: begin
        vs2_off0 = base;
        vs2_off1 = base + idx_t'(1);
      end
    endcase
  end

  always_comb begin
    case (vd_src)
      VD_ZERO: begin
        vd_off0 = '0;
        vd_off1 = '0;
      end
      VD_IDX_PLUS_RS1: begin
        vd_off0 = idx_rs1;
        vd_off1 = idx_rs1 + idx_t'(1);
      end
      VD_IDX_PLUS_UIMM: begin
        vd_off0 = idx_uimm;
        vd_off1 = idx_uimm + idx_t'(1);
      end
      VD_IDX_PLUS_1: begin
        vd_off0 = base + idx_t'(1);
        vd_off1 = base + idx_t'(2);
      end
      default: begin
        vd_off0 = base;
        vd_off1 = base + idx_t'(1);
      end
    endcase
  end

endmodule

// File: source/lane_enable.sv
// per-lane write enables from the v0 mask, the vector length bound and the op kind
`include "vdec_config.svh"

module lane_enable (
  input  vdec_pkg::vop_e    op,
  input  logic              vm,
  input  logic [`VLEN-1:0]  v0_mask,
  input  vdec_pkg::idx_t    offset,
  input  vdec_pkg::idx_t    vl_eff,
  input  vdec_pkg::idx_t    vd_off0,
  input  vdec_pkg::idx_t    vd_off1,
  output logic              wen0,
  output logic              wen1
);
  import vdec_pkg::*;

  localparam int MASK_SEL_W = $clog2(`VLEN);

  logic [$bits(idx_t):0] elem1;
  logic                  in0;
  logic                  in1;
  logic                  mask0;
  logic                  mask1;

  // element bound, lane 1 sits one past lane 0
  assign elem1 = {1'b0, offset} + {1'b0, idx_t'(1)};
  assign in0   = offset < vl_eff;
  assign in1   = elem1 < {1'b0, vl_eff};

  // v0 bit at the destination element, off the end reads as masked off
  assign mask0 = vm || ((vd_off0 < idx_t'(`VLEN)) && v0_mask[vd_off0[MASK_SEL_W-1:0]]);
  assign mask1 = vm || ((vd_off1 < idx_t'(`VLEN)) && v0_mask[vd_off1[MASK_SEL_W-1:0]]);

  always_comb begin
    case (op)
      // stores never write the register file
      OP_STORE: begin
        wen0 = 1'b0;
        wen1 = 1'b0;
      end
      // unmasked single element, lane 1 is never in range
      OP_MV_S_X: begin
        wen0 = in0;
        wen1 = 1'b0;
      end
      default: begin
        wen0 = in0 && mask0;
        wen1 = in1 && mask1;
      end
    endcase
  end

endmodule

// File: source/decode_execute_reg.sv
// decode-to-execute pipeline register for one element pair, with stall hold and flush
module decode_execute_reg (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            stall,
  input  logic            flush,
  input  logic            issue,
  input  logic            last,
  input  vdec_pkg::idx_t  vd_off0,
  input  vdec_pkg::idx_t  vd_off1,
  input  vdec_pkg::idx_t  vs2_off0,
  input  vdec_pkg::idx_t  vs2_off1,
  input  logic            wen0,
  input  logic            wen1,
  output logic            out_valid,
  output logic            out_last,
  output vdec_pkg::idx_t  out_vd_off0,
  output vdec_pkg::idx_t  out_vd_off1,
  output vdec_pkg::idx_t  out_vs2_off0,
  output vdec_pkg::idx_t  out_vs2_off1,
  output logic            out_wen0,
  output logic            out_wen1
);

  // valid, last and the enables
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      out_wen0  <= 1'b0;
      out_wen1  <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      out_wen0  <= 1'b0;
      out_wen1  <= 1'b0;
    end else if (!stall) begin
      // an idle cycle leaves a bubble with everything low
      out_valid <= issue;
      out_last  <= issue && last;
      out_wen0  <= issue && wen0;
      out_wen1  <= issue && wen1;
    end
  end

  // offsets
  always_ff @(posedge CLK) begin
    if (flush) begin
      out_vd_off0  <= '0;
      out_vd_off1  <= '0;
      out_vs2_off0 <= '0;
      out_vs2_off1 <= '0;
    end else if (issue && !stall) begin
      out_vd_off0  <= vd_off0;
      out_vd_off1  <= vd_off1;
      out_vs2_off0 <= vs2_off0;
      out_vs2_off1 <= vs2_off1;
    end
  end

endmodule

// File: source/vdec_top.sv
// top level of the two-lane vector decode sequencer, instanced as the DUT by the testbench
`include "vdec_config.svh"

module vdec_top (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                start,
  input  vdec_pkg::vop_e      op,
  input  vdec_pkg::sew_e      sew,
  input  vdec_pkg::eew_e      eew,
  input  vdec_pkg::vd_src_e   vd_src,
  input  vdec_pkg::vs2_src_e  vs2_src,
  input  logic                vm,
  input  vdec_pkg::idx_t      vl,
  input  vdec_pkg::idx_t      vstart,
  input  vdec_pkg::idx_t      xs1,
  input  logic [4:0]          imm5,
  input  logic [`VLEN-1:0]    v0_mask,
  input  logic                stall,
  input  logic                flush,
  output logic                busy,
  output logic                out_valid,
  output logic                out_last,
  output vdec_pkg::idx_t      out_vd_off0,
  output vdec_pkg::idx_t      out_vd_off1,
  output vdec_pkg::idx_t      out_vs2_off0,
  output vdec_pkg::idx_t      out_vs2_off1,
  output logic                out_wen0,
  output logic                out_wen1
);
  import vdec_pkg::*;

  logic       issue;
  logic       wen0;
  logic       wen1;
  idx_t       vd_off0;
  idx_t       vd_off1;
  idx_t       vs2_off0;
  idx_t       vs2_off1;

  // micro-op fields are only valid in the start cycle
  vop_e       op_q;
  logic       vm_q;
  vd_src_e    vd_src_q;
  vs2_src_e   vs2_src_q;
  idx_t       xs1_q;
  logic [4:0] imm5_q;

  elem_count_if ctr_if ();

  // hold the fields for the whole run
  always_ff @(posedge CLK) begin
    if (ctr_if.load) begin
      op_q      <= op;
      vm_q      <= vm;
      vd_src_q  <= vd_src;
      vs2_src_q <= vs2_src;
      xs1_q     <= xs1;
      imm5_q    <= imm5;
    end
  end

  vdec_fsm i_fsm (
    .CLK   (CLK),
    .nRST  (nRST),
    .start (start),
    .stall (stall),
    .flush (flush),
    .busy  (busy),
    .issue (issue),
    .ctr   (ctr_if.fsm)
  );

  // length math reads the live fields on the load cycle
  element_counter i_counter (
    .CLK    (CLK),
    .nRST   (nRST),
    .op     (op),
    .sew    (sew),
    .eew    (eew),
    .vl     (vl),
    .vstart (vstart),
    .ctr    (ctr_if.counter)
  );

  offset_gen i_offset (
    .ctr      (ctr_if.user),
    .vs2_src  (vs2_src_q),
    .vd_src   (vd_src_q),
    .xs1      (xs1_q),
    .imm5     (imm5_q),
    .vd_off0  (vd_off0),
    .vd_off1  (vd_off1),
    .vs2_off0 (vs2_off0),
    .vs2_off1 (vs2_off1)
  );

  lane_enable i_lane_en (
    .op      (op_q),
    .vm      (vm_q),
    .v0_mask (v0_mask),
    .offset  (ctr_if.offset),
    .vl_eff  (ctr_if.vl_eff),
    .vd_off0 (vd_off0),
    .vd_off1 (vd_off1),
    .wen0    (wen0),
    .wen1    (wen1)
  );

  decode_execute_reg i_de_reg (
    .CLK          (CLK),
    .nRST         (nRST),
    .stall        (stall),
    .flush        (flush),
    .issue        (issue),
    .last         (ctr_if.last),
    .vd_off0      (vd_off0),
    .vd_off1      (vd_off1),
    .vs2_off0     (vs2_off0),
    .vs2_off1     (vs2_off1),
    .wen0         (wen0),
    .wen1         (wen1),
    .out_valid    (out_valid),
    .out_last     (out_last),
    .out_vd_off0  (out_vd_off0),
    .out_vd_off1  (out_vd_off1),
    .out_vs2_off0 (out_vs2_off0),
    .out_vs2_off1 (out_vs2_off1),
    .out_wen0     (out_wen0),
    .out_wen1     (out_wen1)
  );

endmodule

// File: dv/tb_clock_gen.sv
// clock and reset source for the decode sequencer testbench, instanced once by the top module
module tb_clock_gen (
  output logic CLK,
  output logic nRST
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;

  // 10 ns period
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // release reset just after a rising edge, in step with the stimulus
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 nRST = 1'b1;
  end

endmodule

// File: dv/tb_vdec.sv
// directed testbench for the vector decode sequencer, run through files.f as the simulation top
`include "vdec_config.svh"

module tb_vdec;
  timeunit 1ns;
  timeprecision 100ps;
  import vdec_pkg::*;

  // about 40 runs of up to 30 cycles each with stalls, plus reset and margin
  localparam int TIMEOUT_CYCLES = 2000;

  typedef struct packed {
    vop_e             op;
    sew_e             sew;
    eew_e             eew;
    vd_src_e          vd_src;
    vs2_src_e         vs2_src;
    logic             vm;
    idx_t             vl;
    idx_t             vstart;
    idx_t             xs1;
    logic [4:0]       imm5;
    logic [`VLEN-1:0] mask;
  } uop_t;

  typedef struct packed {
    idx_t vd_off0;
    idx_t vd_off1;
    idx_t vs2_off0;
    idx_t vs2_off1;
    logic wen0;
    logic wen1;
    logic last;
  } pair_t;

  logic             CLK;
  logic             nRST;
  logic             start;
  vop_e             op;
  sew_e             sew;
  eew_e             eew;
  vd_src_e          vd_src;
  vs2_src_e         vs2_src;
  logic             vm;
  idx_t             vl;
  idx_t             vstart;
  idx_t             xs1;
  logic [4:0]       imm5;
  logic [`VLEN-1:0] v0_mask;
  logic             stall;
  logic             flush;
  logic             busy;
  logic             out_valid;
  logic             out_last;
  idx_t             out_vd_off0;
  idx_t             out_vd_off1;
  idx_t             out_vs2_off0;
  idx_t             out_vs2_off1;
  logic             out_wen0;
  logic             out_wen1;

  int    seed = 54393;
  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;
  logic  saw_last;
  pair_t exp_q[$];
  pair_t got_q[$];

  tb_clock_gen i_clk (
    .CLK  (CLK),
    .nRST (nRST)
  );

  vdec_top i_dut (
    .CLK          (CLK),
    .nRST         (nRST),
    .start        (start),
    .op           (op),
    .sew          (sew),
    .eew          (eew),
    .vd_src       (vd_src),
    .vs2_src      (vs2_src),
    .vm           (vm),
    .vl           (vl),
    .vstart       (vstart),
    .xs1          (xs1),
    .imm5         (imm5),
    .v0_mask      (v0_mask),
    .stall        (stall),
    .flush        (flush),
    .busy         (busy),
    .out_valid    (out_valid),
    .out_last     (out_last),
    .out_vd_off0  (out_vd_off0),
    .out_vd_off1  (out_vd_off1),
    .out_vs2_off0 (out_vs2_off0),
    .out_vs2_off1 (out_vs2_off1),
    .out_wen0     (out_wen0),
    .out_wen1     (out_wen1)
  );

  // a pair counts as taken by execute when it is valid and not held back
  always @(negedge CLK) begin : capture
    pair_t p;
    if (nRST && out_valid && !stall && !flush) begin
      p.vd_off0  = out_vd_off0;
      p.vd_off1  = out_vd_off1;
      p.vs2_off0 = out_vs2_off0;
      p.vs2_off1 = out_vs2_off1;
      p.wen0     = out_wen0;
      p.wen1     = out_wen1;
      p.last     = out_last;
      got_q.push_back(p);
      if (p.last) begin
        saw_last = 1'b1;
      end
    end
  end

  task automatic check_idx(input string name, input string what, input idx_t exp, input idx_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", name, what, exp, act);
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp, input int act);
    checks++;
    assert (act == exp) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", name, what, exp, act);
    end
  endtask

  function automatic uop_t base_uop(input idx_t vl_val, input idx_t vstart_val);
    uop_t u;
    u.op      = OP_ALU;
    u.sew     = SEW32;
    u.eew     = EEW32;
    u.vd_src  = VD_NORMAL;
    u.vs2_src = VS2_NORMAL;
    u.vm      = 1'b1;
    u.vl      = vl_val;
    u.vstart  = vstart_val;
    u.xs1     = '0;
    u.imm5    = '0;
    u.mask    = '0;
    return u;
  endfunction

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  // reference model
  // memory elements narrower than SEW shrink the element count by the width ratio
  function automatic int expected_vl(input uop_t u);
    int sew_bits;
    int eew_bits;
    sew_bits = 8 << u.sew;
    eew_bits = 8 << u.eew;
    if (u.op == OP_MV_S_X) begin
      return 1;
    end
    if ((u.op == OP_LOAD || u.op == OP_STORE) && eew_bits < sew_bits) begin
      return int'(u.vl) / (sew_bits / eew_bits);
    end
    return int'(u.vl);
  endfunction

  function automatic idx_t vs2_lane(input uop_t u, input int base, input int lane);
    int v;
    case (u.vs2_src)
      VS2_ZERO:          v = 0;
      VS2_IDX_PLUS_RS1:  v = base + int'(u.xs1) + lane;
      VS2_IDX_PLUS_UIMM: v = base + int'(u.imm5) + lane;
      VS2_IDX_PLUS_1:    v = base + 1 + lane;
      VS2_IDX_MINUS_1:   v = base - 1 + lane;
      VS2_RS1:           v = int'(u.xs1);
      VS2_UIMM:          v = int'(u.imm5);
      default:           v = base + lane;
    endcase
    return idx_t'(v);
  endfunction

  function automatic idx_t vd_lane(input uop_t u, input int base, input int lane);
    int v;
    case (u.vd_src)
      VD_ZERO:          v = 0;
      VD_IDX_PLUS_RS1:  v = base + int'(u.xs1) + lane;
      VD_IDX_PLUS_UIMM: v = base + int'(u.imm5) + lane;
      VD_IDX_PLUS_1:    v = base + 1 + lane;
      default:          v = base + lane;
    endcase
    return idx_t'(v);
  endfunction

  function automatic logic mask_on(input uop_t u, input int off);
    if (u.vm) begin
      return 1'b1;
    end
    if (off >= `VLEN) begin
      return 1'b0;
    end
    return u.mask[off];
  endfunction

  function automatic logic lane_wen(input uop_t u, input int vl_eff, input int base,
                                    input int lane, input idx_t vd);
    logic in_range;
    in_range = (base + lane) < vl_eff;
    case (u.op)
      OP_STORE:  return 1'b0;
      OP_MV_S_X: return (lane == 0) && in_range;
      default:   return in_range && mask_on(u, int'(vd));
    endcase
  endfunction

  task automatic build_expected(input uop_t u);
    int    vl_eff;
    int    base;
    logic  done;
    pair_t p;
    vl_eff = expected_vl(u);
    base   = int'(u.vstart);
    done   = 1'b0;
    exp_q.delete();
    // a start at or past the end still yields one empty pair
    while (!done) begin
      p.vd_off0  = vd_lane(u, base, 0);
      p.vd_off1  = vd_lane(u, base, 1);
      p.vs2_off0 = vs2_lane(u, base, 0);
      p.vs2_off1 = vs2_lane(u, base, 1);
      p.wen0     = lane_wen(u, vl_eff, base, 0, p.vd_off0);
      p.wen1     = lane_wen(u, vl_eff, base, 1, p.vd_off1);
      p.last     = (base + 2) >= vl_eff;
      exp_q.push_back(p);
      done = p.last;
      base += 2;
    end
  endtask

  task automatic start_op(input string name, input uop_t u);
    @(posedge CLK);
    #1;
    got_q.delete();
    saw_last = 1'b0;
    op       = u.op;
    sew      = u.sew;
    eew      = u.eew;
    vd_src   = u.vd_src;
    vs2_src  = u.vs2_src;
    vm       = u.vm;
    vl       = u.vl;
    vstart   = u.vstart;
    xs1      = u.xs1;
    imm5     = u.imm5;
    v0_mask  = u.mask;
    stall    = 1'b0;
    start    = 1'b1;
    @(negedge CLK);
    check_bit(name, "busy with start", 1'b1, busy);
    @(posedge CLK);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_run_end(input int stall_pct);
    logic [31:0] r;
    while (!(saw_last && !busy)) begin
      @(posedge CLK);
      #1;
      if (stall_pct > 0) begin
        r = next_random();
        stall = (r % 100) < stall_pct;
      end
    end
    stall = 1'b0;
  endtask

  task automatic compare_pairs(input string name);
    int n;
    int i;
    check_count(name, "pair count", exp_q.size(), got_q.size());
    n = (exp_q.size() < got_q.size()) ? exp_q.size() : got_q.size();
    for (i = 0; i < n; i++) begin
      check_idx(name, $sformatf("pair %0d vd_off0", i), exp_q[i].vd_off0, got_q[i].vd_off0);
      check_idx(name, $sformatf("pair %0d vd_off1", i), exp_q[i].vd_off1, got_q[i].vd_off1);
      check_idx(name, $sformatf("pair %0d vs2_off0", i), exp_q[i].vs2_off0, got_q[i].vs2_off0);
      check_idx(name, $sformatf("pair %0d vs2_off1", i), exp_q[i].vs2_off1, got_q[i].vs2_off1);
      check_bit(name, $sformatf("pair %0d wen0", i), exp_q[i].wen0, got_q[i].wen0);
      check_bit(name, $sformatf("pair %0d wen1", i), exp_q[i].wen1, got_q[i].wen1);
      check_bit(name, $sformatf("pair %0d last", i), exp_q[i].last, got_q[i].last);
    end
  endtask

  task automatic run_op(input string name, input uop_t u, input int stall_pct);
    build_expected(u);
    start_op(name, u);
    wait_run_end(stall_pct);
    compare_pairs(name);
  endtask

  task automatic check_reset_state();
    @(negedge CLK);
    check_bit("reset", "busy", 1'b0, busy);
    check_bit("reset", "out_valid", 1'b0, out_valid);
    check_bit("reset", "out_last", 1'b0, out_last);
    check_bit("reset", "out_wen0", 1'b0, out_wen0);
    check_bit("reset", "out_wen1", 1'b0, out_wen1);
  endtask

  task automatic test_alu_unmasked();
    run_op("alu_vl16", base_uop(idx_t'(16), idx_t'(0)), 0);
    run_op("alu_vl7", base_uop(idx_t'(7), idx_t'(0)), 0);
    run_op("alu_vl9_vs3", base_uop(idx_t'(9), idx_t'(3)), 0);
    run_op("alu_vl4_vs2", base_uop(idx_t'(4), idx_t'(2)), 0);
    run_op("alu_vl1", base_uop(idx_t'(1), idx_t'(0)), 0);
  endtask

  task automatic test_alu_masked();
    uop_t        u;
    logic [31:0] r;
    u    = base_uop(idx_t'(16), idx_t'(0));
    u.vm = 1'b0;
    r    = next_random();
    u.mask = r[`VLEN-1:0];
    run_op("alu_masked_vl16", u, 0);
    u.vl     = idx_t'(11);
    u.vstart = idx_t'(1);
    r        = next_random();
    u.mask   = r[`VLEN-1:0];
    run_op("alu_masked_vl11", u, 0);
  endtask

  task automatic test_load_store();
    uop_t        u;
    logic [31:0] r;
    int          s;
    int          e;
    for (s = 0; s < 3; s++) begin
      for (e = 0; e < 3; e++) begin
        u      = base_uop(idx_t'(16), idx_t'(0));
        u.sew  = sew_e'(s);
        u.eew  = eew_e'(e);
        u.vm   = 1'b0;
        r      = next_random();
        u.mask = r[`VLEN-1:0];
        u.op   = OP_LOAD;
        run_op($sformatf("load_sew%0d_eew%0d", 8 << s, 8 << e), u, 0);
        u.op   = OP_STORE;
        run_op($sformatf("store_sew%0d_eew%0d", 8 << s, 8 << e), u, 0);
      end
    end
  endtask

  task automatic test_mv_s_x();
    uop_t u;
    u    = base_uop(idx_t'(10), idx_t'(0));
    u.op = OP_MV_S_X;
    u.vm = 1'b0;
    run_op("mv_s_x", u, 0);
    // single element write on lane 0 regardless of the mask
    if (got_q.size() > 0) begin
      check_bit("mv_s_x", "wen0", 1'b1, got_q[0].wen0);
      check_bit("mv_s_x", "wen1", 1'b0, got_q[0].wen1);
    end
  endtask

  task automatic test_offset_sources();
    uop_t        u;
    logic [31:0] r;
    u         = base_uop(idx_t'(10), idx_t'(0));
    u.vm      = 1'b0;
    r         = next_random();
    u.mask    = r[`VLEN-1:0];
    u.xs1     = idx_t'(r[17:16]);
    u.imm5    = {2'b00, r[20:18]};
    u.vs2_src = VS2_IDX_PLUS_RS1;
    u.vd_src  = VD_IDX_PLUS_RS1;
    run_op("idx_plus_rs1", u, 0);
    u.vl      = idx_t'(8);
    u.vs2_src = VS2_IDX_PLUS_UIMM;
    u.vd_src  = VD_IDX_PLUS_UIMM;
    run_op("idx_plus_uimm", u, 0);
    u.vl      = idx_t'(9);
    u.vs2_src = VS2_IDX_MINUS_1;
    u.vd_src  = VD_IDX_PLUS_1;
    run_op("idx_minus_1", u, 0);
    u.xs1     = idx_t'(5);
    u.vs2_src = VS2_RS1;
    u.vd_src  = VD_NORMAL;
    run_op("rs1_gather", u, 0);
    u.vs2_src = VS2_UIMM;
    run_op("uimm_gather", u, 0);
    u.vs2_src = VS2_ZERO;
    u.vd_src  = VD_ZERO;
    run_op("zero", u, 0);
    // start beyond the end of the vector
    u         = base_uop(idx_t'(6), idx_t'(8));
    run_op("vstart_past_vl", u, 0);
  endtask

  task automatic test_stall();
    uop_t        u;
    logic [31:0] r;
    u      = base_uop(idx_t'(16), idx_t'(1));
    u.vm   = 1'b0;
    r      = next_random();
    u.mask = r[`VLEN-1:0];
    run_op("stall_alu", u, 40);
    u      = base_uop(idx_t'(16), idx_t'(0));
    u.op   = OP_LOAD;
    u.sew  = SEW16;
    u.eew  = EEW8;
    run_op("stall_load", u, 50);
  endtask

  task automatic test_flush();
    uop_t u;
    int   waited;
    u = base_uop(idx_t'(16), idx_t'(0));
    start_op("flush", u);
    repeat (3) @(posedge CLK);
    #1;
    flush = 1'b1;
    @(posedge CLK);
    #1;
    flush = 1'b0;
    @(negedge CLK);
    check_bit("flush", "out_valid after flush", 1'b0, out_valid);
    waited = 0;
    while (busy && waited < 2) begin
      @(negedge CLK);
      waited++;
    end
    check_bit("flush", "busy after flush", 1'b0, busy);
    run_op("after_flush", base_uop(idx_t'(6), idx_t'(1)), 0);
  endtask

  initial begin : watchdog
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    $display("timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    start    = 1'b0;
    op       = OP_ALU;
    sew      = SEW32;
    eew      = EEW32;
    vd_src   = VD_NORMAL;
    vs2_src  = VS2_NORMAL;
    vm       = 1'b1;
    vl       = '0;
    vstart   = '0;
    xs1      = '0;
    imm5     = '0;
    v0_mask  = '0;
    stall    = 1'b0;
    flush    = 1'b0;
    saw_last = 1'b0;
    wait (nRST === 1'b1);
    check_reset_state();
    test_alu_unmasked();
    test_alu_masked();
    test_load_store();
    test_mv_s_x();
    test_offset_sources();
    test_stall();
    test_flush();
    $display("tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+source
source/vdec_pkg.sv
source/elem_count_if.sv
source/vdec_fsm.sv
source/element_counter.sv
source/offset_gen.sv
source/lane_enable.sv
source/decode_execute_reg.sv
source/vdec_top.sv
dv/tb_clock_gen.sv
dv/tb_vdec.sv

// File: Makefile
TOP := tb_vdec
RTL := $(shell grep '^source/.*\.sv$$' files.f)

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > run.log 2>&1 || (cat run.log; exit 1)
	cat run.log
	! grep -q "Simulation failed" run.log

lint:
	verilator --lint-only -Wall +incdir+source $(RTL) --top-module vdec_top

clean:
	rm -rf obj_dir run.log
